// File: compile.f
fe_pkg.sv
unified_mem.sv
mem_arbiter.sv
fetch_unit.sv
lsu_port.sv
fetch_chk.sv
fe_top.sv
tb_fe_top.sv

// File: fe_input.txt
# Columns: S addr word count | L addr word | R cycles | M target | P mode
# Hex addresses and words, decimal counts; mode 0 stall, 1 ready, 2 random stalls.
P 0
S 0000 13000000 64
S 0040 63000010 1
S 0200 37100000 64
M 0000
P 1
R 10
L 0040 63000010
L 0008 13000002
P 2
R 24
S 00f8 00a00093 1
L 00f8 00a00093
R 12
L 001c 13000007
M 0200
R 30
L 0210 37100004
P 0
R 5
P 1
R 8
L 02fc 3710003f
R 4

// File: fe_pkg.sv
package fe_pkg;

    // Basic widths.
    typedef logic [15:0] t_paddr;   // Byte address.
    typedef logic [31:0] t_word;    // Data or instruction word.

    localparam logic [7:0] OP_BRANCH = 8'h63;   // Conditional branch opcode.

    // Branch encoding of an instruction word.
    typedef struct packed {
        logic [7:0]         opcode;
        logic [7:0]         rsvd;
        logic signed [15:0] offset;    // Signed word offset from the branch pc.
    } t_br_fmt;

    // One instruction word, seen raw or as a branch.
    typedef union packed {
        t_word   plain;
        t_br_fmt br;
    } t_instr;

    // Packet handed from fetch to decode.
    typedef struct packed {
        t_paddr pc;
        t_instr instr;
    } t_instr_pkt;

    // Redirect from execute.
    typedef struct packed {
        t_paddr target_addr;
    } t_br_mispred_pkt;

    // Request into the shared memory port.
    typedef struct packed {
        logic   valid;
        logic   we;        // Set for a store.
        t_paddr addr;
        t_word  wdata;
    } t_mem_req;

    // Read response from the shared memory port.
    typedef struct packed {
        logic  valid;
        t_word rdata;
    } t_mem_rsp;

endpackage

// File: fe_top.sv
`timescale 1ns/1ps

module fe_top import fe_pkg::*; #(
    parameter int     MEM_WORDS = 1024,
    parameter t_paddr RESET_PC  = '0
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            decode_ready,

    input  logic            br_mispred_valid,
    input  t_br_mispred_pkt br_mispred,

    output logic            valid_fe1,
    output t_instr_pkt      instr_fe1,

    input  logic            ld_req,
    input  logic            st_req,
    input  t_paddr          ls_addr,
    input  t_word           st_data,
    output logic            ld_valid,
    output t_word           ld_data,
    output logic            lsu_busy,

    output logic            pc_mismatch
);

    t_mem_req fe_req;
    t_mem_req ls_req;
    t_mem_req mem_req;    // Winner into the memory.
    t_mem_rsp fe_rsp;
    t_mem_rsp ls_rsp;
    t_mem_rsp mem_rsp;
    logic     fe_gnt;
    logic     ls_gnt;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk              (clk),
        .reset            (reset),
        .decode_ready     (decode_ready),
        .br_mispred_valid (br_mispred_valid),
        .br_mispred       (br_mispred),
        .mem_req          (fe_req),
        .mem_gnt          (fe_gnt),
        .mem_rsp          (fe_rsp),
        .valid_fe1        (valid_fe1),
        .instr_fe1        (instr_fe1)
    );

    lsu_port u_lsu (
        .clk      (clk),
        .reset    (reset),
        .ld_req   (ld_req),
        .st_req   (st_req),
        .ls_addr  (ls_addr),
        .st_data  (st_data),
        .mem_req  (ls_req),
        .mem_gnt  (ls_gnt),
        .mem_rsp  (ls_rsp),
        .ld_valid (ld_valid),
        .ld_data  (ld_data),
        .lsu_busy (lsu_busy)
    );

    mem_arbiter u_arb (
        .clk     (clk),
        .reset   (reset),
        .fe_req  (fe_req),
        .ls_req  (ls_req),
        .fe_gnt  (fe_gnt),
        .ls_gnt  (ls_gnt),
        .fe_rsp  (fe_rsp),
        .ls_rsp  (ls_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    unified_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem (
        .clk (clk),
        .req (mem_req),
        .rsp (mem_rsp)
    );

    // Watches the decode side only.
    fetch_chk u_chk (
        .clk              (clk),
        .reset            (reset),
        .decode_ready     (decode_ready),
        .valid_fe1        (valid_fe1),
        .instr_fe1        (instr_fe1),
        .br_mispred_valid (br_mispred_valid),
        .br_mispred       (br_mispred),
        .pc_mismatch      (pc_mismatch)
    );

endmodule

// File: fetch_chk.sv
`timescale 1ns/1ps

module fetch_chk import fe_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            decode_ready,

    input  logic            valid_fe1,
    input  t_instr_pkt      instr_fe1,

    input  logic            br_mispred_valid,
    input  t_br_mispred_pkt br_mispred,

    output logic            pc_mismatch
);

    typedef enum logic [1:0] {
        IDLE,
        PDG_SEQ,
        PDG_BRANCH
    } t_chk_state;

    t_chk_state state;
    t_chk_state state_nxt;
    t_paddr     exp_pc;       // PC the next accepted packet should carry.
    t_paddr     exp_pc_nxt;
    logic       accept;
    logic       mismatch;

    assign accept   = valid_fe1 && decode_ready;
    assign mismatch = accept && (state != IDLE) && (instr_fe1.pc != exp_pc);

    always_comb begin
        state_nxt  = state;
        exp_pc_nxt = exp_pc;
        if (br_mispred_valid) begin
            state_nxt  = PDG_BRANCH;
            exp_pc_nxt = br_mispred.target_addr;       // Redirect resets the stream.
        end else if (accept) begin
            state_nxt = PDG_SEQ;
            unique case (state)
                IDLE:       exp_pc_nxt = instr_fe1.pc + t_paddr'(4);
                PDG_SEQ:    exp_pc_nxt = exp_pc + t_paddr'(4);
                PDG_BRANCH: exp_pc_nxt = exp_pc + t_paddr'(4);
                default:    exp_pc_nxt = exp_pc + t_paddr'(4);
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            exp_pc      <= '0;
            pc_mismatch <= 1'b0;
        end else begin
            state       <= state_nxt;
            exp_pc      <= exp_pc_nxt;
            pc_mismatch <= mismatch;                    // One-cycle pulse.
        end
    end

    // A branch leaving fetch cannot already have been resolved by execute.
    a_no_branch_on_mispred: assert property (
        @(posedge clk) disable iff (reset)
        accept && br_mispred_valid |-> instr_fe1.instr.br.opcode != OP_BRANCH
    ) else $error("branch accepted in the same cycle as a mispredict");

endmodule

// File: fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import fe_pkg::*; #(
    parameter t_paddr RESET_PC = '0
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            decode_ready,

    input  logic            br_mispred_valid,
    input  t_br_mispred_pkt br_mispred,

    output t_mem_req        mem_req,
    input  logic            mem_gnt,
    input  t_mem_rsp        mem_rsp,

    output logic            valid_fe1,
    output t_instr_pkt      instr_fe1
);

    t_paddr     next_pc;      // Address for the next request.
    t_paddr     req_pc;       // Address of the request whose data returns next.
    logic       epoch;        // Flips on every redirect.
    logic       req_epoch;    // Stream the returning request belongs to.
    logic       fetch_en;
    logic       skid_valid;
    t_instr_pkt skid_pkt;     // Packet held while decode stalls.
    t_instr_pkt rsp_pkt;
    logic       rsp_live;
    logic       hold;

    // Drop data from requests issued before the last redirect.
    assign rsp_live = mem_rsp.valid && (req_epoch == epoch);
    assign hold     = valid_fe1 && !decode_ready;

    always_comb begin
        rsp_pkt.pc          = req_pc;
        rsp_pkt.instr.plain = mem_rsp.rdata;
    end

    assign valid_fe1 = skid_valid || rsp_live;
    assign instr_fe1 = skid_valid ? skid_pkt : rsp_pkt;

    // One request and one packet in flight, the next request leaves on accept.
    always_comb begin
        mem_req       = '0;
        mem_req.valid = fetch_en && !hold;
        mem_req.we    = 1'b0;
        mem_req.addr  = next_pc;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_en   <= 1'b0;
            next_pc    <= RESET_PC;
            epoch      <= 1'b0;
            req_epoch  <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            fetch_en <= 1'b1;                        // First request one cycle after reset.
            if (br_mispred_valid) begin
                next_pc    <= br_mispred.target_addr;
                epoch      <= !epoch;                // Anything in flight goes stale.
                skid_valid <= 1'b0;
            end else begin
                if (mem_gnt) begin
                    next_pc <= next_pc + t_paddr'(4);
                end
                skid_valid <= hold;
            end
            if (mem_gnt) begin
                req_epoch <= epoch;
            end
        end
    end

    // Payload only.
    always_ff @(posedge clk) begin
        if (mem_gnt) begin
            req_pc <= next_pc;
        end
        if (hold) begin
            skid_pkt <= instr_fe1;                   // Same packet keeps showing.
        end
    end

    a_pkt_stable: assert property (
        @(posedge clk) disable iff (reset)
        hold && !br_mispred_valid |=> valid_fe1 && $stable(instr_fe1)
    ) else $error("fetch packet changed under back-pressure");

endmodule

// File: lsu_port.sv
`timescale 1ns/1ps

module lsu_port import fe_pkg::*; (
    input  logic     clk,
    input  logic     reset,

    input  logic     ld_req,
    input  logic     st_req,
    input  t_paddr   ls_addr,
    input  t_word    st_data,

    output t_mem_req mem_req,
    input  logic     mem_gnt,
    input  t_mem_rsp mem_rsp,

    output logic     ld_valid,
    output t_word    ld_data,
    output logic     lsu_busy
);

    t_mem_req pend;       // Operation waiting for the memory port.
    logic     wait_rsp;   // Granted load waiting for its data.
    logic     take;

    assign take     = (ld_req || st_req) && !lsu_busy;
    assign lsu_busy = pend.valid || wait_rsp;
    assign mem_req  = pend;                     // Held until granted.
    assign ld_valid = mem_rsp.valid;
    assign ld_data  = mem_rsp.rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            pend.valid <= 1'b0;
            wait_rsp   <= 1'b0;
        end else begin
            if (take) begin
                pend.valid <= 1'b1;
                pend.we    <= st_req;            // Store wins a double strobe.
                pend.addr  <= ls_addr;
                pend.wdata <= st_data;
            end else if (mem_gnt) begin
                pend.valid <= 1'b0;
            end

            if (mem_gnt && !pend.we) begin
                wait_rsp <= 1'b1;
            end else if (mem_rsp.valid) begin
                wait_rsp <= 1'b0;
            end
        end
    end

    a_no_strobe_busy: assert property (
        @(posedge clk) disable iff (reset) (ld_req || st_req) |-> !lsu_busy
    ) else $error("load/store strobe while the port is busy");

endmodule

// File: mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import fe_pkg::*; (
    input  logic     clk,
    input  logic     reset,

    input  t_mem_req fe_req,
    input  t_mem_req ls_req,
    output logic     fe_gnt,
    output logic     ls_gnt,
    output t_mem_rsp fe_rsp,
    output t_mem_rsp ls_rsp,

    output t_mem_req mem_req,
    input  t_mem_rsp mem_rsp
);

    logic owner_ls;   // Load/store port held the memory last cycle.

    // Load/store always wins, fetch takes the port otherwise.
    assign ls_gnt  = ls_req.valid;
    assign fe_gnt  = fe_req.valid && !ls_req.valid;
    assign mem_req = ls_req.valid ? ls_req : fe_req;

    always_ff @(posedge clk) begin
        if (reset) begin
            owner_ls <= 1'b0;
        end else begin
            owner_ls <= ls_gnt;
        end
    end

    // Data goes to both, the valid only to the owner.
    always_comb begin
        fe_rsp       = mem_rsp;
        ls_rsp       = mem_rsp;
        fe_rsp.valid = mem_rsp.valid && !owner_ls;
        ls_rsp.valid = mem_rsp.valid && owner_ls;
    end

    a_one_grant: assert property (
        @(posedge clk) disable iff (reset) $onehot0({fe_gnt, ls_gnt})
    ) else $error("fetch and load/store granted together");

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module tb_fe_top -f compile.f \
    && ./obj_dir/Vtb_fe_top | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }

// File: tb_fe_top.sv
`timescale 1ns/1ps

module tb_fe_top import fe_pkg::*; ();

    localparam t_paddr      RESET_PC  = '0;
    localparam logic [31:0] LFSR_SEED = 32'h92e0a810;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;   // x^32 + x^22 + x^2 + x + 1.

    logic            clk;
    logic            reset;
    logic            decode_ready;
    logic            br_mispred_valid;
    t_br_mispred_pkt br_mispred;
    logic            valid_fe1;
    t_instr_pkt      instr_fe1;
    logic            ld_req;
    logic            st_req;
    t_paddr          ls_addr;
    t_word           st_data;
    logic            ld_valid;
    t_word           ld_data;
    logic            lsu_busy;
    logic            pc_mismatch;

    t_word       model [t_paddr];    // Last word stored at each address.
    t_paddr      exp_pc;
    logic [31:0] lfsr;
    int          ready_mode;         // 0 stall, 1 ready, 2 random.
    logic        held_valid;
    t_instr_pkt  held_pkt;
    logic        after_redirect;
    int          value_errs = 0;
    int          other_errs = 0;
    int          accepted = 0;
    int          loads_done = 0;
    int          branch_words = 0;
    int          run_limit = 0;
    int          watch_cycles = 0;

    fe_top DUT (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ LFSR_TAPS;
        end
        return next;
    endfunction

    task automatic check_packet();
        assert (instr_fe1.pc == exp_pc) else begin
            $display("FAILED %0t instr_fe1.pc expected %h got %h", $time, exp_pc, instr_fe1.pc);
            value_errs++;
        end
        if (!model.exists(instr_fe1.pc)) begin
            $display("Fetch delivered pc %h, which no store has written", instr_fe1.pc);
            other_errs++;
        end else begin
            assert (instr_fe1.instr.plain === model[instr_fe1.pc]) else begin
                $display("FAILED %0t instr_fe1.instr expected %h got %h", $time,
                         model[instr_fe1.pc], instr_fe1.instr.plain);
                value_errs++;
            end
        end
        if (instr_fe1.instr.br.opcode == OP_BRANCH) begin
            branch_words++;
        end
        accepted++;
        exp_pc = exp_pc + t_paddr'(4);   // Sequential stream.
    endtask

    // One clock: sample the registered outputs, then drive the next inputs.
    task automatic advance_cycle(input logic allow_ready);
        logic rdy;
        @(negedge clk);
        ld_req           = 1'b0;
        st_req           = 1'b0;
        br_mispred_valid = 1'b0;
        if (held_valid) begin
            assert (valid_fe1 === 1'b1 && instr_fe1 === held_pkt) else begin
                $display("FAILED %0t instr_fe1 expected %h got %h (valid_fe1 %b)", $time,
                         held_pkt, instr_fe1, valid_fe1);
                value_errs++;
            end
        end
        if (after_redirect) begin
            assert (valid_fe1 === 1'b0) else begin
                $display("FAILED %0t valid_fe1 expected 0 got %b", $time, valid_fe1);
                value_errs++;
            end
        end
        after_redirect = 1'b0;
        assert (pc_mismatch === 1'b0) else begin
            $display("FAILED %0t pc_mismatch expected 0 got %b", $time, pc_mismatch);
            value_errs++;
        end
        case (ready_mode)
            0:       rdy = 1'b0;
            1:       rdy = 1'b1;
            default: begin
                lfsr = lfsr_step(lfsr);
                rdy  = lfsr[0];
            end
        endcase
        if (!allow_ready) begin
            rdy = 1'b0;
        end
        decode_ready = rdy;
        if (valid_fe1 === 1'b1 && rdy) begin
            check_packet();
        end
        held_valid = (valid_fe1 === 1'b1) && !rdy;
        held_pkt   = instr_fe1;
    endtask

    task automatic issue_strobe_check();
        assert (lsu_busy === 1'b0) else begin
            $display("Load/store port still busy at %0t when a strobe was due", $time);
            other_errs++;
        end
    endtask

    task automatic store_words(input t_paddr addr, input t_word data, input int count);
        for (int i = 0; i < count; i++) begin
            advance_cycle(1'b1);
            issue_strobe_check();
            st_req  = 1'b1;
            ls_addr = addr + t_paddr'(i * 4);
            st_data = data + t_word'(i);
            model[ls_addr] = st_data;
            do advance_cycle(1'b1); while (lsu_busy === 1'b1);
        end
    endtask

    task automatic load_check(input t_paddr addr, input t_word exp_word);
        if (!model.exists(addr) || model[addr] !== exp_word) begin
            $display("Load of %h expects %h, which is not the last word stored there",
                     addr, exp_word);
            other_errs++;
        end
        advance_cycle(1'b1);
        issue_strobe_check();
        ld_req  = 1'b1;
        ls_addr = addr;
        do advance_cycle(1'b1); while (ld_valid !== 1'b1);
        assert (ld_data === exp_word) else begin
            $display("FAILED %0t ld_data expected %h got %h", $time, exp_word, ld_data);
            value_errs++;
        end
        loads_done++;
    endtask

    task automatic redirect_fetch(input t_paddr target);
        advance_cycle(1'b0);                   // Nothing accepted with the strobe.
        br_mispred_valid       = 1'b1;
        br_mispred.target_addr = target;
        held_valid             = 1'b0;
        after_redirect         = 1'b1;
        exp_pc                 = target;
    endtask

    initial begin
        wait (run_limit != 0);
        while (watch_cycles < run_limit) begin
            @(posedge clk);
            watch_cycles++;
        end
        $display("Timeout, the run did not finish within %0d cycles", run_limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int             fd;
        int             code;
        int             count;
        int             total;
        logic [7:0]     tok;
        t_paddr         addr;
        t_word          data;
        logic [959:0]   rest;
        clk = 1'b0;
        reset = 1'b1;
        decode_ready = 1'b0;
        br_mispred_valid = 1'b0;
        br_mispred = '0;
        ld_req = 1'b0;
        st_req = 1'b0;
        ls_addr = '0;
        st_data = '0;
        lfsr = LFSR_SEED;
        ready_mode = 0;
        held_valid = 1'b0;
        held_pkt = '0;
        after_redirect = 1'b0;
        exp_pc = RESET_PC;
        total = 0;
        fd = $fopen("fe_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open fe_input.txt");
            other_errs++;
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok == "R") begin
                    code = $fscanf(fd, "%d", count);
                    total += count;
                end else begin
                    code = $fgets(rest, fd);
                end
            end
            $fclose(fd);
            run_limit = 20 * total + 200;
            repeat (3) @(posedge clk);
            @(negedge clk);
            reset = 1'b0;
            fd = $fopen("fe_input.txt", "r");
            while ($fscanf(fd, "%s", tok) == 1) begin
                case (tok)
                    "S": begin
                        code = $fscanf(fd, "%h %h %d", addr, data, count);
                        store_words(addr, data, count);
                    end
                    "L": begin
                        code = $fscanf(fd, "%h %h", addr, data);
                        load_check(addr, data);
                    end
                    "R": begin
                        code = $fscanf(fd, "%d", count);
                        repeat (count) advance_cycle(1'b1);
                    end
                    "M": begin
                        code = $fscanf(fd, "%h", addr);
                        redirect_fetch(addr);
                    end
                    "P": begin
                        code = $fscanf(fd, "%d", count);
                        ready_mode = count;
                    end
                    "#":     code = $fgets(rest, fd);
                    default: begin
                        $display("Unknown command %s in fe_input.txt", tok);
                        other_errs++;
                        code = $fgets(rest, fd);
                    end
                endcase
            end
            $fclose(fd);
            repeat (2) advance_cycle(1'b0);    // Catch a late pc_mismatch pulse.
        end
        $display("Errors: %0d value, %0d other; %0d packets, %0d loads, %0d branch words",
                 value_errs, other_errs, accepted, loads_done, branch_words);
        if (value_errs + other_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: unified_mem.sv
`timescale 1ns/1ps

module unified_mem import fe_pkg::*; #(
    parameter int MEM_WORDS = 1024
) (
    input  logic     clk,
    input  t_mem_req req,
    output t_mem_rsp rsp
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    t_word                      mem [MEM_WORDS];   // Shared instruction and data words.
    logic [$bits(t_paddr)-3:0]  word_addr;         // Byte offset dropped.
    logic [IDX_W-1:0]           idx;

    assign word_addr = req.addr[$bits(t_paddr)-1:2];
    assign idx       = word_addr[IDX_W-1:0];

    // Stores write straight into the array, reads come back one cycle later.
    always_ff @(posedge clk) begin
        if (req.valid && req.we) begin
            mem[idx] <= req.wdata;               // Visible to a read in the next cycle.
        end
        rsp.valid <= req.valid && !req.we;       // Stores get no response.
        rsp.rdata <= mem[idx];
    end

    // Any granted address must fall inside the implemented depth.
    a_addr_in_range: assert property (
        @(posedge clk) req.valid |-> (32'(word_addr) < MEM_WORDS)
    ) else $error("memory address %h outside of %0d words", req.addr, MEM_WORDS);

endmodule
